// ==== hw/bfly_pkg.sv ====
// Full-rate butterfly only; every width below derives from IWIDTH=16 and assumes a 20-bit twiddle
package bfly_pkg;

    // ==================================================
    // Base widths
    // ==================================================
    // Input sample component
    localparam int IWIDTH = 16;
    // Twiddle carries four extra bits of precision
    localparam int CWIDTH = IWIDTH + 4;
    // One bit of growth from the add or subtract
    localparam int OWIDTH = IWIDTH + 1;

    // ==================================================
    // Derived widths
    // ==================================================
    // Sum and difference components
    localparam int DWIDTH = IWIDTH + 1;
    // P1 and P2 partial products
    localparam int PWIDTH = DWIDTH + CWIDTH;
    // P3 and the rebuilt product, two bits wider from the pre-adds
    localparam int MWIDTH = CWIDTH + IWIDTH + 3;
    // Sum scaled up to the product binary point
    localparam int SWIDTH = CWIDTH + IWIDTH + 1;
    // Top bits thrown away ahead of rounding
    localparam int SUM_DROP = 2;
    localparam int MPY_DROP = 4;
    // Low bits discarded by the rounder, identical on both paths
    localparam int FWIDTH = SWIDTH - SUM_DROP - OWIDTH;
    // Enabled clocks from input to output
    localparam int LATENCY = 6;

    // ==================================================
    // Component types
    // ==================================================
    typedef logic signed [IWIDTH-1:0] sample_t;
    typedef logic signed [CWIDTH-1:0] coef_t;
    typedef logic signed [DWIDTH-1:0] diff_t;
    typedef logic signed [PWIDTH-1:0] prod_t;
    typedef logic signed [MWIDTH-1:0] mprod_t;
    typedef logic signed [SWIDTH-1:0] ssum_t;
    typedef logic signed [OWIDTH-1:0] out_t;

    // Complex values, real part in the upper half
    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_sample_t;

    typedef struct packed {
        coef_t re;
        coef_t im;
    } cplx_coef_t;

    typedef struct packed {
        diff_t re;
        diff_t im;
    } cplx_diff_t;

    typedef struct packed {
        mprod_t re;
        mprod_t im;
    } cplx_mprod_t;

    typedef struct packed {
        ssum_t re;
        ssum_t im;
    } cplx_ssum_t;

    typedef struct packed {
        out_t re;
        out_t im;
    } cplx_out_t;

endpackage

// ==== hw/bfly_input_stage.sv ====
// Two enabled clocks deep; operand and twiddle data are unreset and only meaningful once flushed
`timescale 1ns/1ps

module bfly_input_stage
    import bfly_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_reset,
    input  logic         i_ce,
    input  cplx_sample_t i_left,
    input  cplx_sample_t i_right,
    input  cplx_coef_t   i_coef,
    input  logic         i_aux,
    output cplx_diff_t   o_sum,
    output cplx_diff_t   o_dif,
    output cplx_coef_t   o_coef,
    output logic         o_aux
);

    // First stage operand capture
    cplx_sample_t r_left;
    cplx_sample_t r_right;
    cplx_coef_t   r_coef;
    // First sync register, second one is o_aux
    logic         r_aux;

    // ==================================================
    // Sync flag chain
    // ==================================================
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            r_aux <= 1'b0;
            o_aux <= 1'b0;
        end
        else if (i_ce)
        begin
            // Clock 1 capture
            r_aux <= i_aux;
            // Clock 2, lines up with sum and difference
            o_aux <= r_aux;
        end
    end

    // ==================================================
    // Operand capture and add/subtract
    // ==================================================
    always_ff @(posedge i_clk)
    begin
        if (i_ce)
        begin
            // Clock 1 isolates the inputs from outside routing
            r_left  <= i_left;
            r_right <= i_right;
            r_coef  <= i_coef;

            // Clock 2 sum path, widened by one bit to hold the carry
            o_sum.re <= diff_t'(r_left.re) + diff_t'(r_right.re);
            o_sum.im <= diff_t'(r_left.im) + diff_t'(r_right.im);

            // Clock 2 difference path
            o_dif.re <= diff_t'(r_left.re) - diff_t'(r_right.re);
            o_dif.im <= diff_t'(r_left.im) - diff_t'(r_right.im);

            // Twiddle waits one more register so it meets the difference
            o_coef <= r_coef;
        end
    end

    // Sync must be a clean level once reset has cleared the chain
    a_aux_known : assert property (
        @(posedge i_clk) disable iff (i_reset)
        !$isunknown(o_aux)
    ) else $error("input stage sync flag is unknown after reset");

endmodule

// ==== hw/bfly_cmul.sv ====
// Three-multiplier complex product, three enabled clocks deep; no reset, data flushes through
`timescale 1ns/1ps

module bfly_cmul
    import bfly_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_ce,
    input  cplx_diff_t  i_dif,
    input  cplx_coef_t  i_coef,
    output cplx_mprod_t o_prod
);

    // ==================================================
    // Pipeline registers
    // ==================================================
    // P1 operands, real times real
    coef_t p1c;
    diff_t p1d;
    // P2 operands, imaginary times imaginary
    coef_t p2c;
    diff_t p2d;
    // P3 operands carry one extra bit from the pre-add
    logic signed [CWIDTH:0] p3c;
    logic signed [DWIDTH:0] p3d;

    // Multiplier outputs
    prod_t  rp_one;
    prod_t  rp_two;
    mprod_t rp_three;

    // P1 and P2 sign-extended to the P3 width
    mprod_t w_one;
    mprod_t w_two;

    // Imaginary part one bit wider, used to spot overflow
    logic signed [MWIDTH:0] im_wide;

    // ==================================================
    // Clock 1, pre-add
    // ==================================================
    always_ff @(posedge i_clk)
    begin
        if (i_ce)
        begin
            p1c <= i_coef.re;
            p1d <= i_dif.re;
            p2c <= i_coef.im;
            p2d <= i_dif.im;
            // Karatsuba pre-add, sum of components on both sides
            p3c <= (CWIDTH+1)'(i_coef.re) + (CWIDTH+1)'(i_coef.im);
            p3d <= (DWIDTH+1)'(i_dif.re) + (DWIDTH+1)'(i_dif.im);
        end
    end

    // ==================================================
    // Clock 2, the three multipliers
    // ==================================================
    always_ff @(posedge i_clk)
    begin
        if (i_ce)
        begin
            // Operands sign-extended first so the full product is kept
            rp_one   <= prod_t'(p1c) * prod_t'(p1d);
            rp_two   <= prod_t'(p2c) * prod_t'(p2d);
            rp_three <= mprod_t'(p3c) * mprod_t'(p3d);
        end
    end

    // ==================================================
    // Clock 3, rebuild real and imaginary parts
    // ==================================================
    // Two bits of sign extension match P3
    assign w_one = mprod_t'(rp_one);
    assign w_two = mprod_t'(rp_two);

    always_ff @(posedge i_clk)
    begin
        if (i_ce)
        begin
            // cr*dr - ci*di
            o_prod.re <= w_one - w_two;
            // (cr+ci)(dr+di) - cr*dr - ci*di = cr*di + ci*dr
            o_prod.im <= rp_three - w_one - w_two;
        end
    end

    // Same subtraction as above with a guard bit
    assign im_wide = (MWIDTH+1)'(rp_three) - (MWIDTH+1)'(w_one) - (MWIDTH+1)'(w_two);

    // Guard bit must agree with the sign bit, else mprod_t wrapped
    a_prod_fits : assert property (
        @(posedge i_clk)
        (i_ce && !$isunknown(im_wide)) |-> (im_wide[MWIDTH] == im_wide[MWIDTH-1])
    ) else $error("imaginary product overflows its width");

endmodule

// ==== hw/bfly_sum_align.sv ====
// Sum path delay of three enabled clocks to match the multiplier; only the sync bits are reset
`timescale 1ns/1ps

module bfly_sum_align
    import bfly_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_ce,
    input  cplx_diff_t i_sum,
    input  logic       i_aux,
    output cplx_ssum_t o_sum,
    output logic       o_aux
);

    // Sum delay line, stage 2 feeds the scaler
    cplx_diff_t sum_dly [0:2];
    // Sync flag rides alongside the sum
    logic [2:0] aux_dly;

    // ==================================================
    // Delay line
    // ==================================================
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            aux_dly <= '0;
        end
        else if (i_ce)
        begin
            aux_dly <= {aux_dly[1:0], i_aux};
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_ce)
        begin
            sum_dly[0] <= i_sum;
            sum_dly[1] <= sum_dly[0];
            sum_dly[2] <= sum_dly[1];
        end
    end

    // ==================================================
    // Scale to the product binary point
    // ==================================================
    // Product carries CWIDTH-2 fraction bits from the twiddle
    // Two sign bits on top line up the integer part
    assign o_sum.re = {{2{sum_dly[2].re[DWIDTH-1]}}, sum_dly[2].re, {(CWIDTH-2){1'b0}}};
    assign o_sum.im = {{2{sum_dly[2].im[DWIDTH-1]}}, sum_dly[2].im, {(CWIDTH-2){1'b0}}};

    assign o_aux = aux_dly[2];

endmodule

// ==== hw/bfly_out_stage.sv ====
// Convergent rounding to OWIDTH bits in one enabled clock; top bits dropped are assumed redundant
`timescale 1ns/1ps

module bfly_out_stage
    import bfly_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        i_ce,
    input  cplx_ssum_t  i_sum,
    input  cplx_mprod_t i_prod,
    input  logic        i_aux,
    output cplx_out_t   o_left,
    output cplx_out_t   o_right,
    output logic        o_aux
);

    // ==================================================
    // Round half to even
    // ==================================================
    // Kept bits plus a carry, the carry decided by the discarded part
    function automatic out_t conv_round(input out_t kept, input logic [FWIDTH-1:0] frac);
        logic [FWIDTH-1:0] half;
        logic              round_up;
        half = {1'b1, {(FWIDTH-1){1'b0}}};
        // Above half always rounds up, exact half only toward an even result
        round_up = (frac > half) || ((frac == half) && kept[0]);
        return kept + out_t'(round_up);
    endfunction

    // Rounded components before the output register
    out_t rnd_left_re;
    out_t rnd_left_im;
    out_t rnd_right_re;
    out_t rnd_right_im;

    // Sum path, SUM_DROP top bits dropped
    assign rnd_left_re = conv_round(i_sum.re[SWIDTH-1-SUM_DROP -: OWIDTH],
                                    i_sum.re[FWIDTH-1:0]);
    assign rnd_left_im = conv_round(i_sum.im[SWIDTH-1-SUM_DROP -: OWIDTH],
                                    i_sum.im[FWIDTH-1:0]);

    // Product path, MPY_DROP top bits dropped
    assign rnd_right_re = conv_round(i_prod.re[MWIDTH-1-MPY_DROP -: OWIDTH],
                                     i_prod.re[FWIDTH-1:0]);
    assign rnd_right_im = conv_round(i_prod.im[MWIDTH-1-MPY_DROP -: OWIDTH],
                                     i_prod.im[FWIDTH-1:0]);

    // ==================================================
    // Output register
    // ==================================================
    always_ff @(posedge i_clk)
    begin
        if (i_ce)
        begin
            o_left.re  <= rnd_left_re;
            o_left.im  <= rnd_left_im;
            o_right.re <= rnd_right_re;
            o_right.im <= rnd_right_im;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            o_aux <= 1'b0;
        end
        else if (i_ce)
        begin
            o_aux <= i_aux;
        end
    end

    // Sync output may only move on an enabled clock, reset aside
    a_aux_on_ce : assert property (
        @(posedge i_clk)
        (!$past(i_ce) && !$past(i_reset)) |-> $stable(o_aux)
    ) else $error("output sync changed without a clock enable");

endmodule

// ==== hw/hwbfly_top.sv ====
// DIF radix-2 butterfly, one sample per enabled clock, fixed latency of 6; no back-pressure
`timescale 1ns/1ps

module hwbfly_top
    import bfly_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_reset,
    input  logic         i_ce,
    input  cplx_sample_t i_left,
    input  cplx_sample_t i_right,
    input  cplx_coef_t   i_coef,
    input  logic         i_aux,
    output cplx_out_t    o_left,
    output cplx_out_t    o_right,
    output logic         o_aux
);

    // Input side to the two branches
    cplx_diff_t  sum_w;
    cplx_diff_t  dif_w;
    cplx_coef_t  coef_w;
    logic        sum_aux_w;
    // Branches to the output side
    cplx_mprod_t prod_w;
    cplx_ssum_t  ssum_w;
    logic        ssum_aux_w;

    bfly_input_stage u_input (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_ce    (i_ce),
        .i_left  (i_left),
        .i_right (i_right),
        .i_coef  (i_coef),
        .i_aux   (i_aux),
        .o_sum   (sum_w),
        .o_dif   (dif_w),
        .o_coef  (coef_w),
        .o_aux   (sum_aux_w)
    );

    // Difference times twiddle
    bfly_cmul u_cmul (
        .i_clk  (i_clk),
        .i_ce   (i_ce),
        .i_dif  (dif_w),
        .i_coef (coef_w),
        .o_prod (prod_w)
    );

    // Sum waits for the product
    bfly_sum_align u_sum_align (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_ce    (i_ce),
        .i_sum   (sum_w),
        .i_aux   (sum_aux_w),
        .o_sum   (ssum_w),
        .o_aux   (ssum_aux_w)
    );

    bfly_out_stage u_output (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_ce    (i_ce),
        .i_sum   (ssum_w),
        .i_prod  (prod_w),
        .i_aux   (ssum_aux_w),
        .o_left  (o_left),
        .o_right (o_right),
        .o_aux   (o_aux)
    );

endmodule

// ==== include/bfly_tb_ref.svh ====
// Include inside a scope that imports bfly_pkg; 64-bit integer model, valid for these widths only
`ifndef BFLY_TB_REF_SVH
`define BFLY_TB_REF_SVH

// ==================================================
// Fibonacci LFSR, taps 32 22 2 1
// ==================================================
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], fb};
endfunction

// One step per bit, newest bit lands in the LSB
function automatic logic [63:0] lfsr_bits(inout logic [31:0] state, input int nbits);
    logic [63:0] bits;
    bits = '0;
    for (int k = 0; k < nbits; k++)
    begin
        state = lfsr_next(state);
        bits  = {bits[62:0], state[0]};
    end
    return bits;
endfunction

// ==================================================
// Rounding model
// ==================================================
// Dropped top bits vanish in the final truncation to OWIDTH
function automatic out_t ref_round(input longint val, input int width, input int drop);
    int     fbits;
    longint q;
    longint r;
    longint half;
    fbits = width - drop - OWIDTH;
    half  = longint'(1) <<< (fbits - 1);
    // Floor division, remainder always non-negative
    q = val >>> fbits;
    r = val - (q <<< fbits);
    if ((r > half) || ((r == half) && q[0]))
        q = q + 1;
    return out_t'(q);
endfunction

// ==================================================
// Reference butterfly
// ==================================================
function automatic void ref_bfly(input cplx_sample_t a, input cplx_sample_t b,
                                 input cplx_coef_t c, output cplx_out_t left,
                                 output cplx_out_t right);
    longint sum_re;
    longint sum_im;
    longint dif_re;
    longint dif_im;
    longint p1;
    longint p2;
    longint p3;
    sum_re = longint'(a.re) + longint'(b.re);
    sum_im = longint'(a.im) + longint'(b.im);
    dif_re = longint'(a.re) - longint'(b.re);
    dif_im = longint'(a.im) - longint'(b.im);
    // Exact product by the three-multiplier rule
    p1 = longint'(c.re) * dif_re;
    p2 = longint'(c.im) * dif_im;
    p3 = (longint'(c.re) + longint'(c.im)) * (dif_re + dif_im);
    left.re  = ref_round(sum_re <<< (CWIDTH - 2), SWIDTH, SUM_DROP);
    left.im  = ref_round(sum_im <<< (CWIDTH - 2), SWIDTH, SUM_DROP);
    right.re = ref_round(p1 - p2, MWIDTH, MPY_DROP);
    right.im = ref_round(p3 - p1 - p2, MWIDTH, MPY_DROP);
endfunction

`endif

// ==== dv/tb_hwbfly.sv ====
// Self-checking testbench for hwbfly_top; needs simulator timing support, run from the project root
`timescale 1ns/1ps

module tb_hwbfly
    import bfly_pkg::*;
();

    `include "bfly_tb_ref.svh"

    // ==================================================
    // Test lengths and time limit
    // ==================================================
    localparam int RESET_CYCLES = 5;
    localparam int N_CORNER     = 49;
    localparam int N_SYNC       = 20;
    localparam int N_RAND       = 2000;
    localparam int N_GAP        = 600;
    localparam int N_TIE        = 24;
    // Gap test spends at most two clocks per sample and the flush adds LATENCY plus two
    localparam int STIM_CLOCKS  = RESET_CYCLES + N_CORNER + N_SYNC + N_RAND + 2 * N_GAP
                                  + N_TIE + LATENCY + 2;
    localparam int WATCHDOG_NS  = (STIM_CLOCKS + LATENCY + 100) * 4;

    // Expected outputs of one accepted sample
    typedef struct packed {
        cplx_out_t left;
        cplx_out_t right;
        logic      aux;
    } result_t;

    // DUT ports
    logic         i_clk = 1'b0;
    logic         i_reset;
    logic         i_ce;
    cplx_sample_t i_left;
    cplx_sample_t i_right;
    cplx_coef_t   i_coef;
    logic         i_aux;
    cplx_out_t    o_left;
    cplx_out_t    o_right;
    logic         o_aux;

    // Stimulus state
    logic [31:0]  lfsr_state;
    string        cur_name;

    // Scoreboard holds one entry per enabled clock
    result_t      exp_q [$];
    string        name_q [$];
    result_t      pend;
    result_t      got;
    string        got_name;
    int           n_pushed;
    int           n_checked;

    // Enable and reset seen at the last rising edge
    logic         edge_ce;
    logic         edge_reset;
    // Outputs seen at the previous falling edge
    cplx_out_t    last_left;
    cplx_out_t    last_right;
    logic         last_aux;

    hwbfly_top i_dut (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_ce    (i_ce),
        .i_left  (i_left),
        .i_right (i_right),
        .i_coef  (i_coef),
        .i_aux   (i_aux),
        .o_left  (o_left),
        .o_right (o_right),
        .o_aux   (o_aux)
    );

    // 4 ns period
    always #2 i_clk = ~i_clk;

    // ==================================================
    // Random values from the LFSR
    // ==================================================
    function automatic cplx_sample_t operand_value();
        logic [63:0]  bits;
        cplx_sample_t v;
        bits = lfsr_bits(lfsr_state, IWIDTH);
        v.re = sample_t'(bits[IWIDTH-1:0]);
        bits = lfsr_bits(lfsr_state, IWIDTH);
        v.im = sample_t'(bits[IWIDTH-1:0]);
        return v;
    endfunction

    function automatic cplx_coef_t twiddle_value();
        logic [63:0] bits;
        cplx_coef_t  v;
        bits = lfsr_bits(lfsr_state, CWIDTH);
        v.re = coef_t'(bits[CWIDTH-1:0]);
        bits = lfsr_bits(lfsr_state, CWIDTH);
        v.im = coef_t'(bits[CWIDTH-1:0]);
        return v;
    endfunction

    function automatic logic flip_bit();
        logic [63:0] bits;
        bits = lfsr_bits(lfsr_state, 1);
        return bits[0];
    endfunction

    // ==================================================
    // Compare tasks
    // ==================================================
    task automatic check_out(input string name, input cplx_out_t exp, input cplx_out_t act);
        if (exp !== act)
        begin
            $display("mismatch %s expected re=%0d im=%0d actual re=%0d im=%0d",
                     name, exp.re, exp.im, act.re, act.im);
            $display("SOME TESTS FAILED");
            $fatal(1, "output compare failed");
        end
    endtask

    task automatic check_aux(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            $display("mismatch %s expected aux=%b actual aux=%b", name, exp, act);
            $display("SOME TESTS FAILED");
            $fatal(1, "sync compare failed");
        end
    endtask

    // ==================================================
    // Drivers that change inputs 1 ns after the rising edge
    // ==================================================
    task automatic drive_operands(input string name, input cplx_sample_t a,
                                  input cplx_sample_t b, input cplx_coef_t c, input logic aux);
        @(posedge i_clk);
        #1;
        cur_name = name;
        i_ce     = 1'b1;
        i_left   = a;
        i_right  = b;
        i_coef   = c;
        i_aux    = aux;
    endtask

    // Disabled clock with junk on the inputs that must not be taken
    task automatic idle_clock();
        @(posedge i_clk);
        #1;
        i_ce    = 1'b0;
        i_left  = operand_value();
        i_right = operand_value();
        i_coef  = twiddle_value();
        i_aux   = flip_bit();
    endtask

    // ==================================================
    // Reference side samples the inputs on the rising edge
    // ==================================================
    always @(posedge i_clk)
    begin
        edge_ce    = i_ce && !i_reset;
        edge_reset = i_reset;
        if (edge_ce)
        begin
            ref_bfly(i_left, i_right, i_coef, pend.left, pend.right);
            pend.aux = i_aux;
            exp_q.push_back(pend);
            name_q.push_back(cur_name);
            n_pushed++;
        end
    end

    // ==================================================
    // Comparing process on the falling edge
    // ==================================================
    always @(negedge i_clk)
    begin
        if (edge_reset)
        begin
            check_aux("aux_reset", 1'b0, o_aux);
        end
        else if (edge_ce && (exp_q.size() >= LATENCY))
        begin
            // Output now reflects the sample taken LATENCY enabled clocks back
            got      = exp_q.pop_front();
            got_name = name_q.pop_front();
            check_out({got_name, " left"}, got.left, o_left);
            check_out({got_name, " right"}, got.right, o_right);
            check_aux(got_name, got.aux, o_aux);
            n_checked++;
        end
        else if (edge_ce)
        begin
            // Pipeline still filling so the sync chain is still low from reset
            check_aux("aux_fill", 1'b0, o_aux);
        end
        else
        begin
            check_out("ce_hold left", last_left, o_left);
            check_out("ce_hold right", last_right, o_right);
            check_aux("ce_hold aux", last_aux, o_aux);
        end
        last_left  = o_left;
        last_right = o_right;
        last_aux   = o_aux;
    end

    // ==================================================
    // Watchdog
    // ==================================================
    initial
    begin
        #(WATCHDOG_NS);
        $display("run hung, no end of test after %0d ns", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    // ==================================================
    // Test sequence
    // ==================================================
    initial
    begin
        cplx_sample_t a;
        cplx_sample_t b;
        cplx_coef_t   c;
        sample_t      corner [0:6];
        sample_t      odd_val [0:7];
        coef_t        tie_coef [0:2];

        lfsr_state = 32'h917ae2de;
        cur_name   = "reset";
        n_pushed   = 0;
        n_checked  = 0;
        edge_ce    = 1'b0;
        edge_reset = 1'b1;
        i_reset    = 1'b1;
        i_ce       = 1'b0;
        i_left     = '0;
        i_right    = '0;
        i_coef     = '0;
        i_aux      = 1'b0;

        // Full scale, zero, unit and alternating bit patterns
        corner   = '{16'sh7fff, 16'sh8000, 16'sh0000, 16'sh0001,
                     16'shffff, 16'sh5555, 16'shaaaa};
        odd_val  = '{16'sd1, 16'sd3, 16'sd5, 16'sd7, -16'sd1, -16'sd3, -16'sd5, -16'sd7};
        // Odd difference times these twiddles leaves exactly half in the dropped bits
        tie_coef = '{coef_t'(131072), coef_t'(393216), coef_t'(-131072)};

        repeat (RESET_CYCLES) @(posedge i_clk);
        #1;
        i_reset = 1'b0;

        // Sum path corners
        for (int i = 0; i < 7; i++)
        begin
            for (int j = 0; j < 7; j++)
            begin
                a.re = corner[i];
                a.im = corner[j];
                b.re = corner[j];
                b.im = corner[(i + 1) % 7];
                drive_operands("sum_corner", a, b, twiddle_value(), 1'b0);
            end
        end

        // One sync pulse in a quiet stream
        for (int k = 0; k < N_SYNC; k++)
        begin
            drive_operands("sync_pulse", operand_value(), operand_value(),
                           twiddle_value(), (k == 5));
        end

        // Difference path with enable held high
        for (int k = 0; k < N_RAND; k++)
        begin
            drive_operands("dif_random", operand_value(), operand_value(),
                           twiddle_value(), 1'b0);
        end

        // Idle clock before about half the samples leaves a third of all clocks idle
        for (int k = 0; k < N_GAP; k++)
        begin
            if (flip_bit())
            begin
                idle_clock();
            end
            drive_operands("ce_gaps", operand_value(), operand_value(),
                           twiddle_value(), flip_bit());
        end

        // Rounding ties on even and odd kept values
        b = '0;
        for (int t = 0; t < 3; t++)
        begin
            for (int v = 0; v < 8; v++)
            begin
                a.re = odd_val[v];
                a.im = odd_val[7-v];
                if (t == 1)
                begin
                    c.re = '0;
                    c.im = tie_coef[t];
                end
                else
                begin
                    c.re = tie_coef[t];
                    c.im = '0;
                end
                drive_operands("round_tie", a, b, c, 1'b0);
            end
        end

        // Push the last real samples out of the pipeline
        repeat (LATENCY) drive_operands("flush", '0, '0, '0, 1'b0);
        idle_clock();
        @(negedge i_clk);
        #1;

        if (n_checked == n_pushed - (LATENCY - 1))
        begin
            $display("ALL TESTS PASSED");
            $finish;
        end
        else
        begin
            $display("only %0d of %0d results were compared", n_checked,
                     n_pushed - (LATENCY - 1));
            $display("SOME TESTS FAILED");
            $fatal(1, "result count is wrong");
        end
    end

endmodule

// ==== files.f ====
+incdir+include
hw/bfly_pkg.sv
hw/bfly_input_stage.sv
hw/bfly_cmul.sv
hw/bfly_sum_align.sv
hw/bfly_out_stage.sv
hw/hwbfly_top.sv
dv/tb_hwbfly.sv

// ==== Makefile ====
# Verilator build for the butterfly and its testbench

FILELIST := files.f
LOG      := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f $(FILELIST) --top-module hwbfly_top

sim:
	verilator --binary --timing --assert -f $(FILELIST) --top-module tb_hwbfly \
		-Mdir obj_dir -o tb_hwbfly_sim
	./obj_dir/tb_hwbfly_sim > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
